// File: logic/iic_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iic_pkg
// shared definitions of the APB-driven I2C master: transaction
// phase encoding, APB widths, register map and bit positions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package iic_pkg;

    // one-hot transaction phase
    typedef enum logic [6:0] {
        ST_IDLE         = 7'b000_0001,  // bus released
        ST_START_WADDR  = 7'b000_0010,  // start, device address, write bit
        ST_WORD_ADDR    = 7'b000_0100,  // word address bytes
        ST_WDATA        = 7'b000_1000,  // write data bytes
        ST_RSTART_RADDR = 7'b001_0000,  // repeated start, device address, read bit
        ST_RDATA        = 7'b010_0000,  // read data bytes
        ST_STOP         = 7'b100_0000   // stop bit
    } iic_state_t;

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;  // also widest word a transfer carries

    // register map
    localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS    = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_WORD_ADDR = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_WDATA     = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_RDATA     = 8'h10;
    localparam logic [APB_ADDR_W-1:0] REG_DEV_ADDR  = 8'h14;

    localparam int CTRL_START_BIT     = 0;
    localparam int CTRL_READ_BIT      = 1;
    localparam int STATUS_READY_BIT   = 0;
    localparam int STATUS_ACK_ERR_BIT = 1;
    localparam int STATUS_DONE_BIT    = 2;

endpackage

`default_nettype wire

// File: logic/iic_apb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iic_apb_regs
// zero-wait-state APB slave holding the transfer setup, issuing
// the start pulse to the sequencer and capturing its results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module iic_apb_regs #(
    parameter int         ADDR_BYTE_NUM  = 1,
    parameter int         DATA_BYTE_NUM  = 4,
    parameter logic [6:0] DEV_ADDR_RESET = 7'h50
) (
    input  wire                             iic_clk,
    input  wire                             iic_rst,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire [iic_pkg::APB_ADDR_W-1:0]   paddr,
    input  wire [iic_pkg::APB_DATA_W-1:0]   pwdata,
    output logic [iic_pkg::APB_DATA_W-1:0]  prdata,
    output logic                            pslverr,
    input  wire                             busy,
    input  wire                             done,
    input  wire [DATA_BYTE_NUM*8-1:0]       rdata,
    input  wire                             ack_error,
    output logic                            cmd_start,
    output logic                            cmd_read,
    output logic [6:0]                      dev_addr,
    output logic [ADDR_BYTE_NUM*8-1:0]      word_addr,
    output logic [DATA_BYTE_NUM*8-1:0]      wdata
);
    import iic_pkg::*;

    logic                       access;     // APB access phase
    logic                       addr_hit;   // offset is mapped
    logic                       start_req;  // CTRL write with start bit
    logic                       wr_en;
    logic                       ready;
    logic                       done_flag;  // sticky until next start
    logic                       ack_err_q;
    logic [DATA_BYTE_NUM*8-1:0] rdata_q;

    assign access    = psel && penable;
    assign start_req = access && pwrite && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];
    assign pslverr   = access && (!addr_hit || (start_req && (!ready || busy)));
    assign wr_en     = access && pwrite && ready && !pslverr;  // setup frozen during a transfer

    // read mux, valid in access phase
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            REG_CTRL:      prdata[CTRL_READ_BIT] = cmd_read;  // start bit reads 0
            REG_STATUS: begin
                prdata[STATUS_READY_BIT]   = ready;
                prdata[STATUS_ACK_ERR_BIT] = ack_err_q;
                prdata[STATUS_DONE_BIT]    = done_flag;
            end
            REG_WORD_ADDR: prdata[ADDR_BYTE_NUM*8-1:0] = word_addr;
            REG_WDATA:     prdata[DATA_BYTE_NUM*8-1:0] = wdata;
            REG_RDATA:     prdata[DATA_BYTE_NUM*8-1:0] = rdata_q;
            REG_DEV_ADDR:  prdata[6:0] = dev_addr;
            default:       addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge iic_clk or posedge iic_rst) begin
        if (iic_rst) begin
            cmd_start <= 1'b0;
            cmd_read  <= 1'b0;
            ready     <= 1'b1;
            done_flag <= 1'b0;
            ack_err_q <= 1'b0;
            dev_addr  <= DEV_ADDR_RESET;
        end else begin
            cmd_start <= wr_en && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];  // one cycle
            if (wr_en && (paddr == REG_CTRL)) begin
                cmd_read <= pwdata[CTRL_READ_BIT];
                if (pwdata[CTRL_START_BIT]) begin
                    ready     <= 1'b0;  // same edge as the start pulse
                    done_flag <= 1'b0;
                end
            end
            if (wr_en && (paddr == REG_DEV_ADDR))
                dev_addr <= pwdata[6:0];
            if (done) begin  // sequencer back to idle
                ready     <= 1'b1;
                done_flag <= 1'b1;
                ack_err_q <= ack_error;
            end
        end
    end

    // payload
    always_ff @(posedge iic_clk) begin
        if (wr_en && (paddr == REG_WORD_ADDR))
            word_addr <= pwdata[ADDR_BYTE_NUM*8-1:0];
        if (wr_en && (paddr == REG_WDATA))
            wdata <= pwdata[DATA_BYTE_NUM*8-1:0];
        if (done)
            rdata_q <= rdata;  // also loaded after writes
    end

endmodule

`default_nettype wire

// File: logic/iic_scl_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iic_scl_timing
// per-bit divider, SCL_DIV clocks per bit, with registered
// strobes for SCL edges, SDA update and SDA sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module iic_scl_timing #(
    parameter int SCL_DIV = 16
) (
    input  wire  iic_clk,
    input  wire  iic_rst,
    input  wire  run,
    output logic scl_fall,
    output logic scl_rise,
    output logic sda_write,
    output logic sda_sample,
    output logic bit_end
);
    localparam int CNT_W = $clog2(SCL_DIV);

    localparam logic [CNT_W-1:0] CNT_QTR  = CNT_W'(SCL_DIV / 4);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(SCL_DIV / 2);
    localparam logic [CNT_W-1:0] CNT_3QTR = CNT_W'(SCL_DIV * 3 / 4);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_DIV - 1);

    logic [CNT_W-1:0] cnt;
    logic [4:0]       strb_q;  // fall, rise, write, sample, end

    always_ff @(posedge iic_clk or posedge iic_rst) begin
        if (iic_rst)
            cnt <= '0;
        else if (!run || (cnt == CNT_LAST))
            cnt <= '0;  // held at zero while idle
        else
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge iic_clk or posedge iic_rst) begin
        if (iic_rst)
            strb_q <= '0;
        else if (!run)
            strb_q <= '0;
        else
            strb_q <= {cnt == '0, cnt == CNT_HALF, cnt == CNT_QTR,
                       cnt == CNT_3QTR, cnt == CNT_LAST};
    end

    // mask the strobe left over from the last bit of a transfer
    assign {scl_fall, scl_rise, sda_write, sda_sample, bit_end} = strb_q & {5{run}};

endmodule

`default_nettype wire

// File: logic/iic_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iic_sequencer
// I2C transaction FSM: start, device address, word address,
// write or repeated-start read, stop. Drives SCL and the SDA
// pull-down, shifts in read data and checks slave acks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module iic_sequencer #(
    parameter int ADDR_BYTE_NUM = 1,
    parameter int DATA_BYTE_NUM = 4
) (
    input  wire                         iic_clk,
    input  wire                         iic_rst,
    input  wire                         cmd_start,
    input  wire                         cmd_read,
    input  wire [6:0]                   dev_addr,
    input  wire [ADDR_BYTE_NUM*8-1:0]   word_addr,
    input  wire [DATA_BYTE_NUM*8-1:0]   wdata,
    input  wire                         scl_fall,
    input  wire                         scl_rise,
    input  wire                         sda_write,
    input  wire                         sda_sample,
    input  wire                         bit_end,
    input  wire                         iic_sda_in,
    output logic                        run,
    output logic                        busy,
    output logic                        done,
    output logic [DATA_BYTE_NUM*8-1:0]  rdata,
    output logic                        ack_error,
    output logic                        iic_scl,
    output logic                        iic_sda_oe
);
    import iic_pkg::*;

    localparam logic [1:0] ADDR_LAST = 2'(ADDR_BYTE_NUM - 1);
    localparam logic [1:0] DATA_LAST = 2'(DATA_BYTE_NUM - 1);

    iic_state_t state;
    iic_state_t state_nxt;
    logic [3:0] bit_cnt;     // bit within phase
    logic [1:0] byte_cnt;    // byte within multi-byte phase
    logic       addr_phase;  // 10-bit phases
    logic       last_bit;
    logic       last_byte;
    logic [8:0] addr_frame;  // start slot, address, r/w
    logic [7:0] tx_byte;

    assign addr_phase = (state == ST_START_WADDR) || (state == ST_RSTART_RADDR);
    assign last_bit   = bit_end && ((state == ST_STOP) || (bit_cnt == (addr_phase ? 4'd9 : 4'd8)));
    assign last_byte  = byte_cnt == ((state == ST_WORD_ADDR) ? ADDR_LAST : DATA_LAST);
    assign addr_frame = {1'b0, dev_addr, state == ST_RSTART_RADDR};
    assign tx_byte    = (state == ST_WORD_ADDR) ?
                        word_addr[(ADDR_BYTE_NUM - 1 - byte_cnt) * 8 +: 8] :
                        wdata[(DATA_BYTE_NUM - 1 - byte_cnt) * 8 +: 8];  // msb byte first

    assign run  = state != ST_IDLE;
    assign busy = state != ST_IDLE;
    assign done = (state == ST_STOP) && bit_end;  // last cycle before idle

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:         if (cmd_start) state_nxt = ST_START_WADDR;
            ST_START_WADDR:  if (last_bit) state_nxt = ST_WORD_ADDR;
            ST_WORD_ADDR: begin
                if (last_bit && last_byte)
                    state_nxt = cmd_read ? ST_RSTART_RADDR : ST_WDATA;
            end
            ST_WDATA:        if (last_bit && last_byte) state_nxt = ST_STOP;
            ST_RSTART_RADDR: if (last_bit) state_nxt = ST_RDATA;
            ST_RDATA:        if (last_bit && last_byte) state_nxt = ST_STOP;
            ST_STOP:         if (last_bit) state_nxt = ST_IDLE;
            default:         state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge iic_clk or posedge iic_rst) begin
        if (iic_rst) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE || last_bit)
                bit_cnt <= '0;
            else if (bit_end)
                bit_cnt <= bit_cnt + 1'b1;
            if (state == ST_IDLE || (last_bit && last_byte))
                byte_cnt <= '0;
            else if (last_bit && !addr_phase)
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // SCL stays high through the start bit
    always_ff @(posedge iic_clk or posedge iic_rst) begin
        if (iic_rst)
            iic_scl <= 1'b1;
        else if (state == ST_IDLE || scl_rise)
            iic_scl <= 1'b1;
        else if (scl_fall && !(state == ST_START_WADDR && bit_cnt == 4'd0))
            iic_scl <= 1'b0;
    end

    // SDA pull-down, 1 pulls the line low
    always_ff @(posedge iic_clk or posedge iic_rst) begin
        if (iic_rst) begin
            iic_sda_oe <= 1'b0;
        end else if (sda_write) begin
            case (state)
                ST_START_WADDR, ST_RSTART_RADDR: begin
                    if (bit_cnt == 4'd9 || (state == ST_RSTART_RADDR && bit_cnt == 4'd0))
                        iic_sda_oe <= 1'b0;  // ack slot, or high before repeated start
                    else
                        iic_sda_oe <= !addr_frame[4'd8 - bit_cnt];  // bit 0 gives start
                end
                ST_WORD_ADDR, ST_WDATA:
                    iic_sda_oe <= (bit_cnt != 4'd8) && !tx_byte[3'd7 - bit_cnt[2:0]];
                ST_RDATA:
                    iic_sda_oe <= (bit_cnt == 4'd8) && !last_byte;  // ack, nack on last
                ST_STOP:
                    iic_sda_oe <= 1'b1;  // low ahead of stop
                default:
                    iic_sda_oe <= 1'b0;
            endcase
        end else if (sda_sample) begin
            if (state == ST_RSTART_RADDR && bit_cnt == 4'd0)
                iic_sda_oe <= 1'b1;  // repeated start, SCL high
            else if (state == ST_STOP)
                iic_sda_oe <= 1'b0;  // stop, SCL high
        end
    end

    // missing ack on any transmitted byte
    always_ff @(posedge iic_clk or posedge iic_rst) begin
        if (iic_rst)
            ack_error <= 1'b0;
        else if (cmd_start && state == ST_IDLE)
            ack_error <= 1'b0;
        else if (sda_sample && ((addr_phase && bit_cnt == 4'd9) ||
                 ((state == ST_WORD_ADDR || state == ST_WDATA) && bit_cnt == 4'd8)))
            ack_error <= ack_error | iic_sda_in;
    end

    // read shifter, msb byte and bit first
    always_ff @(posedge iic_clk) begin
        if (sda_sample && state == ST_RDATA && bit_cnt < 4'd8)
            rdata <= {rdata[DATA_BYTE_NUM*8-2:0], iic_sda_in};
    end

endmodule

`default_nettype wire

// File: logic/iic_master_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iic_master_top
// APB-controlled I2C master: register block, bit timing and
// transaction sequencer. SDA is open drain, tristate at the pad
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module iic_master_top #(
    parameter int         ADDR_BYTE_NUM  = 1,      // 1 or 2
    parameter int         DATA_BYTE_NUM  = 4,      // 1 to 4
    parameter int         SCL_DIV        = 16,     // clocks per SCL bit, >= 8
    parameter logic [6:0] DEV_ADDR_RESET = 7'h50
) (
    input  wire                             iic_clk,
    input  wire                             iic_rst,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire [iic_pkg::APB_ADDR_W-1:0]   paddr,
    input  wire [iic_pkg::APB_DATA_W-1:0]   pwdata,
    output logic [iic_pkg::APB_DATA_W-1:0]  prdata,
    output logic                            pslverr,
    output logic                            iic_scl,
    output logic                            iic_sda_oe,  // 1 pulls SDA low
    input  wire                             iic_sda_in
);
    wire                       cmd_start;
    wire                       cmd_read;
    wire [6:0]                 dev_addr;
    wire [ADDR_BYTE_NUM*8-1:0] word_addr;
    wire [DATA_BYTE_NUM*8-1:0] wdata;
    wire [DATA_BYTE_NUM*8-1:0] rdata;
    wire                       busy;
    wire                       done;
    wire                       ack_error;
    wire                       run;
    wire                       scl_fall;
    wire                       scl_rise;
    wire                       sda_write;
    wire                       sda_sample;
    wire                       bit_end;

    iic_apb_regs #(
        .ADDR_BYTE_NUM (ADDR_BYTE_NUM),
        .DATA_BYTE_NUM (DATA_BYTE_NUM),
        .DEV_ADDR_RESET(DEV_ADDR_RESET)
    ) i_regs (
        .iic_clk  (iic_clk),
        .iic_rst  (iic_rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pslverr  (pslverr),
        .busy     (busy),
        .done     (done),
        .rdata    (rdata),
        .ack_error(ack_error),
        .cmd_start(cmd_start),
        .cmd_read (cmd_read),
        .dev_addr (dev_addr),
        .word_addr(word_addr),
        .wdata    (wdata)
    );

    iic_scl_timing #(
        .SCL_DIV(SCL_DIV)
    ) i_timing (
        .iic_clk   (iic_clk),
        .iic_rst   (iic_rst),
        .run       (run),
        .scl_fall  (scl_fall),
        .scl_rise  (scl_rise),
        .sda_write (sda_write),
        .sda_sample(sda_sample),
        .bit_end   (bit_end)
    );

    iic_sequencer #(
        .ADDR_BYTE_NUM(ADDR_BYTE_NUM),
        .DATA_BYTE_NUM(DATA_BYTE_NUM)
    ) i_seq (
        .iic_clk   (iic_clk),
        .iic_rst   (iic_rst),
        .cmd_start (cmd_start),
        .cmd_read  (cmd_read),
        .dev_addr  (dev_addr),
        .word_addr (word_addr),
        .wdata     (wdata),
        .scl_fall  (scl_fall),
        .scl_rise  (scl_rise),
        .sda_write (sda_write),
        .sda_sample(sda_sample),
        .bit_end   (bit_end),
        .iic_sda_in(iic_sda_in),
        .run       (run),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .ack_error (ack_error),
        .iic_scl   (iic_scl),
        .iic_sda_oe(iic_sda_oe)
    );

endmodule

`default_nettype wire

// File: test/iic_eeprom_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// iic_eeprom_model
// behavioral 256-byte I2C EEPROM slave on an open-drain bus,
// one word address byte, sequential access with wrap
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module iic_eeprom_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input  wire  scl,
    input  wire  sda,
    output logic sda_oe  // 1 pulls SDA low
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PH_IDLE  = 0;  // waiting for start
    localparam int PH_DEV   = 1;  // device address byte
    localparam int PH_WORD  = 2;  // word address byte
    localparam int PH_WRITE = 3;  // data bytes into memory
    localparam int PH_READ  = 4;  // data bytes out of memory

    logic [7:0] mem [256];
    logic [7:0] ptr = 8'd0;      // word pointer, wraps
    logic [7:0] rx_byte = 8'd0;
    logic [7:0] tx_byte = 8'd0;
    logic       ack = 1'b0;      // answer for current ack slot
    logic       drive = 1'b0;
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    int         phase = PH_IDLE;
    int         phase_nxt = PH_IDLE;  // taken at end of ack slot
    int         bit_cnt = 0;          // 8 is the ack slot

    assign sda_oe = drive;

    initial begin
        for (int i = 0; i < 256; i++)
            mem[8'(i)] = 8'(i) ^ 8'h5A;  // fill depends on the address
        forever begin
            @(scl or sda);
            if (scl && scl_q && sda_q && !sda) begin  // start or repeated start
                phase   = PH_DEV;
                bit_cnt = 0;
            end else if (scl && scl_q && !sda_q && sda) begin
                phase = PH_IDLE;  // stop
            end else if (scl && !scl_q && phase != PH_IDLE) begin
                if (bit_cnt < 8) begin
                    if (phase != PH_READ)
                        rx_byte = {rx_byte[6:0], sda};
                    bit_cnt++;
                    if (bit_cnt == 8 && phase == PH_DEV) begin
                        ack       = rx_byte[7:1] == DEV_ADDR;
                        phase_nxt = !ack ? PH_IDLE : (rx_byte[0] ? PH_READ : PH_WORD);
                    end else if (bit_cnt == 8 && phase == PH_WORD) begin
                        ptr       = rx_byte;
                        phase_nxt = PH_WRITE;
                    end else if (bit_cnt == 8 && phase == PH_WRITE) begin
                        mem[ptr]  = rx_byte;
                        ptr       = ptr + 8'd1;
                        phase_nxt = PH_WRITE;
                    end
                end else begin
                    bit_cnt = 0;
                    if (phase == PH_READ)
                        phase = sda ? PH_IDLE : PH_READ;  // master nack ends read
                    else
                        phase = phase_nxt;
                end
            end else if (!scl && scl_q) begin  // SCL low, slave may change SDA
                if (phase == PH_IDLE) begin
                    drive = 1'b0;
                end else if (bit_cnt == 8) begin
                    drive = (phase != PH_READ) && ack;
                end else if (phase == PH_READ) begin
                    if (bit_cnt == 0) begin
                        tx_byte = mem[ptr];
                        ptr     = ptr + 8'd1;
                    end
                    drive   = !tx_byte[7];  // msb first
                    tx_byte = tx_byte << 1;
                end else begin
                    drive = 1'b0;
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_iic_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_iic_master
// testbench for the APB I2C master against an EEPROM model:
// reset state, random write/read pairs, nack, bus errors, wrap
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_iic_master;
    timeunit 1ns;
    timeprecision 1ps;

    import iic_pkg::*;

    localparam int SCL_DIV     = 16;
    localparam int TRANSFERS   = 48;  // all tests together
    localparam int MAX_BITS    = 70;  // longest transfer, a 4-byte read
    localparam int CYCLE_LIMIT = 2 * TRANSFERS * MAX_BITS * SCL_DIV;  // about 100k
    localparam int POLL_LIMIT  = 1000;  // status reads per transfer

    localparam logic [6:0]  EEPROM_ADDR = 7'h50;
    localparam logic [31:0] CMD_WRITE   = 32'd1 << CTRL_START_BIT;
    localparam logic [31:0] CMD_READ    = CMD_WRITE | (32'd1 << CTRL_READ_BIT);
    localparam logic [31:0] STAT_DONE   = (32'd1 << STATUS_READY_BIT) |
                                          (32'd1 << STATUS_DONE_BIT);
    localparam logic [31:0] STAT_NACK   = STAT_DONE | (32'd1 << STATUS_ACK_ERR_BIT);

    logic                  iic_clk;
    logic                  iic_rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pslverr;
    logic                  iic_scl;
    logic                  iic_sda_oe;
    logic                  eeprom_sda_oe;
    wire                   sda;

    logic [7:0]  mirror [256];  // expected EEPROM contents
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_base = 0;  // error count when a test began

    assign sda = !(iic_sda_oe || eeprom_sda_oe);  // open drain, released reads 1

    iic_master_top #(
        .ADDR_BYTE_NUM (1),
        .DATA_BYTE_NUM (4),
        .SCL_DIV       (SCL_DIV),
        .DEV_ADDR_RESET(EEPROM_ADDR)
    ) i_dut (
        .iic_clk   (iic_clk),
        .iic_rst   (iic_rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .iic_scl   (iic_scl),
        .iic_sda_oe(iic_sda_oe),
        .iic_sda_in(sda)
    );

    iic_eeprom_model #(
        .DEV_ADDR(EEPROM_ADDR)
    ) i_eeprom (
        .scl   (iic_scl),
        .sda   (sda),
        .sda_oe(eeprom_sda_oe)
    );

    initial begin
        iic_clk = 1'b0;
        forever #20 iic_clk = ~iic_clk;  // 40 ns period
    end

    always @(posedge iic_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests still running after %0d clock cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // one zero-wait APB transfer, response sampled mid access phase
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] data, output logic [31:0] rd,
                              output logic err);
        @(posedge iic_clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge iic_clk);
        #2;
        penable = 1'b1;
        @(negedge iic_clk);
        rd  = prdata;
        err = pslverr;
        @(posedge iic_clk);  // access completes here
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        check_equal("pslverr on write", {31'd0, err}, 32'd0);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'd0, data, err);
        check_equal("pslverr on read", {31'd0, err}, 32'd0);
    endtask

    task automatic check_status(input string what, input logic [31:0] exp);
        logic [31:0] status;
        apb_read(REG_STATUS, status);
        check_equal(what, status, exp);
    endtask

    // poll STATUS until the done flag shows up
    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[STATUS_DONE_BIT] && polls < POLL_LIMIT) begin
            apb_read(REG_STATUS, status);
            polls++;
        end
        if (!status[STATUS_DONE_BIT]) begin
            $display("transfer never reported done after %0d status reads", polls);
            errors++;
        end
    endtask

    task automatic start_transfer(input logic [7:0] addr, input logic [31:0] data,
                                  input logic [31:0] cmd);
        apb_write(REG_WORD_ADDR, {24'd0, addr});
        apb_write(REG_WDATA, data);
        apb_write(REG_CTRL, cmd);
    endtask

    task automatic eeprom_write(input logic [7:0] addr, input logic [31:0] data);
        start_transfer(addr, data, CMD_WRITE);
        wait_done();
    endtask

    task automatic eeprom_read(input logic [7:0] addr, output logic [31:0] data);
        start_transfer(addr, 32'd0, CMD_READ);
        wait_done();
        apb_read(REG_RDATA, data);
    endtask

    task automatic mirror_store(input logic [7:0] addr, input logic [31:0] data);
        logic [7:0]  a;
        logic [31:0] word;
        a    = addr;
        word = data;
        repeat (4) begin
            mirror[a] = word[31:24];  // msb byte at lowest address
            word      = word << 8;
            a         = a + 8'd1;     // wraps past 0xff
        end
    endtask

    function automatic logic [31:0] mirror_word(input logic [7:0] addr);
        return {mirror[addr], mirror[addr + 8'd1], mirror[addr + 8'd2], mirror[addr + 8'd3]};
    endfunction

    task automatic report_test(input string name);
        $display("%0d ns: test %s finished, %0d errors", $time, name, errors - test_base);
        test_base = errors;
        tests++;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] data;
        logic [7:0]  addr;
        logic        err;
        void'($urandom(32'h77ee_4705));  // seeds the random sequence once
        iic_rst = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < 256; i++)
            mirror[8'(i)] = 8'(i) ^ 8'h5A;  // power-up contents of the EEPROM
        repeat (5) @(posedge iic_clk);
        #2;
        iic_rst = 1'b0;

        apb_read(REG_STATUS, rd);
        check_equal("STATUS after reset", rd, 32'd1 << STATUS_READY_BIT);
        apb_read(REG_DEV_ADDR, rd);
        check_equal("DEV_ADDR after reset", rd, {25'd0, EEPROM_ADDR});
        check_equal("SCL after reset", {31'd0, iic_scl}, 32'd1);
        check_equal("SDA pull-down after reset", {31'd0, iic_sda_oe}, 32'd0);
        report_test("reset state");

        for (int n = 0; n < 20; n++) begin
            addr = 8'($urandom);
            data = $urandom;
            eeprom_write(addr, data);
            mirror_store(addr, data);
            check_status("STATUS after write", STAT_DONE);
            eeprom_read(addr, rd);
            check_equal("RDATA after write", rd, mirror_word(addr));
            check_status("STATUS after read", STAT_DONE);
        end
        report_test("write then read back");

        apb_write(REG_DEV_ADDR, 32'h23);  // nobody answers here
        addr = 8'($urandom);
        data = $urandom;
        eeprom_write(addr, data);
        check_status("STATUS after nacked write", STAT_NACK);
        apb_write(REG_DEV_ADDR, {25'd0, EEPROM_ADDR});
        eeprom_read(addr, rd);
        check_equal("RDATA after nacked write", rd, mirror_word(addr));
        check_status("STATUS after read", STAT_DONE);
        report_test("wrong device address");

        addr = 8'($urandom);
        data = $urandom;
        start_transfer(addr, data, CMD_WRITE);
        apb_access(1'b1, REG_CTRL, CMD_READ, rd, err);  // second start while busy
        check_equal("pslverr on start while busy", {31'd0, err}, 32'd1);
        wait_done();
        mirror_store(addr, data);
        check_status("STATUS after refused start", STAT_DONE);
        eeprom_read(addr, rd);
        check_equal("RDATA after refused start", rd, mirror_word(addr));
        apb_access(1'b0, 8'h18, 32'd0, rd, err);
        check_equal("pslverr on unmapped read", {31'd0, err}, 32'd1);
        apb_access(1'b1, 8'h20, 32'hFFFF_FFFF, rd, err);
        check_equal("pslverr on unmapped write", {31'd0, err}, 32'd1);
        report_test("bus errors");

        data = $urandom;
        eeprom_write(8'hFE, data);
        mirror_store(8'hFE, data);
        eeprom_read(8'h00, rd);
        check_equal("RDATA at 0x00 after wrap", rd, mirror_word(8'h00));
        check_equal("wrapped bytes at 0x00", {16'd0, rd[31:16]}, {16'd0, data[15:0]});
        eeprom_read(8'hFE, rd);
        check_equal("RDATA across 0xff", rd, data);
        report_test("page wrap");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/iic_pkg.sv
logic/iic_apb_regs.sv
logic/iic_scl_timing.sv
logic/iic_sequencer.sv
logic/iic_master_top.sv
test/iic_eeprom_model.sv
test/tb_iic_master.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_iic_master
FLIST     ?= flist.f

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir
